// File: Bender.yml
package:
  name: video_shifter

sources:
  - verilog/shifter_pkg.sv
  - verilog/cpu_reg_pkg.sv
  - verilog/video_timing.sv
  - verilog/video_regs.sv
  - verilog/video_fetch.sv
  - verilog/line_buffer.sv
  - verilog/pixel_shifter.sv
  - verilog/video_top.sv
  - target: test
    files:
      - tb/tb_video.sv

// File: tb.f
verilog/shifter_pkg.sv
verilog/cpu_reg_pkg.sv
verilog/video_timing.sv
verilog/video_regs.sv
verilog/video_fetch.sv
verilog/line_buffer.sv
verilog/pixel_shifter.sv
verilog/video_top.sv
tb/tb_video.sv

// File: tb/tb_video.sv
////////////////////////////////////////////////////////////////////////////
// video shifter testbench, memory model, directed tests, compare tasks
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module tb_video;

  localparam int v_act = 8;
  localparam int v_tot = 12;
  localparam int h_tot = 800;
  localparam int clk_period = 20;
  localparam int frame_ns = h_tot * v_tot * clk_period;
  localparam int num_tests = 6;
  // four frames per test plus two frames of margin
  localparam int watchdog_ns = (num_tests * 4 + 2) * frame_ns;

  logic clk;
  logic ss;
  cpu_reg_pkg::reg_req_t reg_req;
  shifter_pkg::word_t reg_dout;
  shifter_pkg::vaddr_t vaddr;
  logic read;
  shifter_pkg::word_t data;
  shifter_pkg::rgb_t rgb;
  logic hs;
  logic vs;
  logic de;

  // reference state kept by the tests
  integer seed = 32'h70d3a5c1;
  shifter_pkg::word_t key;
  shifter_pkg::vaddr_t base_m;
  shifter_pkg::rgb_t pal_m [16];
  shifter_pkg::vaddr_t req_addr;
  logic mem_pend = 1'b0;
  int errors = 0;
  int tests_run = 0;
  int tests_failed = 0;

  video_top #(
    .v_active (v_act),
    .v_total  (v_tot)
  ) DUT (
    .clk      (clk),
    .ss       (ss),
    .reg_req  (reg_req),
    .reg_dout (reg_dout),
    .vaddr    (vaddr),
    .read     (read),
    .data     (data),
    .rgb      (rgb),
    .hs       (hs),
    .vs       (vs),
    .de       (de)
  );

  initial begin
    clk = 1'b0;
    forever #(clk_period / 2) clk = ~clk;
  end

  initial begin
    #(watchdog_ns);
    $display("timeout: the tests did not finish within the expected number of frames");
    $display("*** TEST FAILED ***");
    $finish;
  end

  // screen word mixing the whole address with the per test key
  function automatic shifter_pkg::word_t mem_word(shifter_pkg::vaddr_t a);
    return shifter_pkg::word_t'(a[15:0] ^ {a[6:0], a[22:14]}) ^ key;
  endfunction

  // strobe and address taken mid cycle
  always @(negedge clk) begin
    mem_pend = read;
    req_addr = vaddr;
  end

  // memory answers one cycle after the strobe
  always @(posedge clk) begin
    if (mem_pend) begin
      #2;
      data = mem_word(req_addr);
    end
  end

  // pixel x of display line L from the fetch rules
  function automatic shifter_pkg::rgb_t expect_pixel(shifter_pkg::shmode_t m, int line, int x);
    shifter_pkg::vaddr_t a;
    shifter_pkg::word_t w [4];
    int row;
    int bitn;
    logic [3:0] idx;
    row = (line - 1) / 2;
    if (m == shifter_pkg::SH_MONO) begin
      a = base_m + shifter_pkg::vaddr_t'(shifter_pkg::WORDS_MONO * (line - 1) + x / 16);
      w[0] = mem_word(a);
      return (w[0][15 - x % 16] ^ pal_m[0].b[0]) ? 9'h1ff : 9'h000;
    end
    if (m == shifter_pkg::SH_MED) begin
      a = base_m + shifter_pkg::vaddr_t'(shifter_pkg::WORDS_COLOR * row + 2 * (x / 16));
      bitn = 15 - x % 16;
      w[0] = mem_word(a);
      w[1] = mem_word(a + 23'd1);
      idx = {2'b00, w[1][bitn], w[0][bitn]};
    end else begin
      // low resolution pixels are two clocks wide
      a = base_m + shifter_pkg::vaddr_t'(shifter_pkg::WORDS_COLOR * row + 4 * (x / 32));
      bitn = 15 - (x % 32) / 2;
      for (int i = 0; i < 4; i++) begin
        w[i] = mem_word(a + shifter_pkg::vaddr_t'(i));
      end
      idx = {w[3][bitn], w[2][bitn], w[1][bitn], w[0][bitn]};
    end
    return pal_m[idx];
  endfunction

  task automatic check_word(string what, shifter_pkg::word_t got, shifter_pkg::word_t exp);
    if (got !== exp) begin
      errors++;
      $display("Fail at %0t: %s got %h expected %h", $time, what, got, exp);
    end
  endtask

  task automatic check_rgb(string what, shifter_pkg::rgb_t got, shifter_pkg::rgb_t exp);
    if (got !== exp) begin
      errors++;
      $display("Fail at %0t: %s got rgb %h expected %h", $time, what, got, exp);
    end
  endtask

  task automatic check_addr(string what, shifter_pkg::vaddr_t got, shifter_pkg::vaddr_t exp);
    if (got !== exp) begin
      errors++;
      $display("Fail at %0t: %s got address %h expected %h", $time, what, got, exp);
    end
  endtask

  task automatic reg_idle();
    reg_req = '{sel: 1'b0, rw: 1'b1, uds: 1'b1, lds: 1'b1, addr: 6'd0, din: 16'd0};
  endtask

  task automatic reg_write(logic [5:0] addr, shifter_pkg::word_t din, logic uds, logic lds);
    @(posedge clk);
    #2;
    reg_req = '{sel: 1'b1, rw: 1'b0, uds: uds, lds: lds, addr: addr, din: din};
    @(posedge clk);
    #2;
    reg_idle();
  endtask

  // combinational readback sampled before the next edge
  task automatic reg_read(logic [5:0] addr, output shifter_pkg::word_t val);
    @(posedge clk);
    #2;
    reg_req = '{sel: 1'b1, rw: 1'b1, uds: 1'b0, lds: 1'b0, addr: addr, din: 16'd0};
    #1;
    val = reg_dout;
    reg_idle();
  endtask

  task automatic read_vaddr(output shifter_pkg::vaddr_t a);
    shifter_pkg::word_t hi;
    shifter_pkg::word_t mid;
    shifter_pkg::word_t lo;
    reg_read(cpu_reg_pkg::ADDR_VADDR_HI, hi);
    reg_read(cpu_reg_pkg::ADDR_VADDR_MID, mid);
    reg_read(cpu_reg_pkg::ADDR_VADDR_LO, lo);
    a = {hi[7:0], mid[7:0], lo[7:1]};
  endtask

  task automatic write_base(logic [15:0] b);
    reg_write(cpu_reg_pkg::ADDR_BASE_HI, {8'h00, b[15:8]}, 1'b1, 1'b0);
    reg_write(cpu_reg_pkg::ADDR_BASE_MID, {8'h00, b[7:0]}, 1'b1, 1'b0);
    base_m = {b, 7'd0};
  endtask

  task automatic write_palette(int idx, shifter_pkg::rgb_t c);
    reg_write(6'(cpu_reg_pkg::ADDR_PALETTE + idx),
              {5'd0, c.r, 1'b0, c.g, 1'b0, c.b}, 1'b0, 1'b0);
    pal_m[idx] = c;
  endtask

  task automatic set_mode(shifter_pkg::shmode_t m);
    reg_write(cpu_reg_pkg::ADDR_SHMODE, {6'd0, m, 8'd0}, 1'b0, 1'b1);
  endtask

  // one frame of displayed lines from the end of vsync
  task automatic check_frame(shifter_pkg::shmode_t m);
    int x;
    for (int line = 1; line <= v_act; line++) begin
      do @(negedge clk); while (!de);
      x = 0;
      while (de) begin
        check_rgb($sformatf("line %0d pixel %0d", line, x), rgb, expect_pixel(m, line, x));
        x++;
        @(negedge clk);
      end
      check_word($sformatf("line %0d pixel count", line), 16'(x), 16'(shifter_pkg::H_ACT));
    end
  endtask

  task automatic end_test(string name, int errs_before);
    tests_run++;
    if (errors == errs_before) begin
      $display("test %s: ok", name);
    end else begin
      tests_failed++;
      $display("test %s: %0d errors", name, errors - errs_before);
    end
  endtask

  task automatic test_reset();
    int e0;
    shifter_pkg::word_t w;
    shifter_pkg::vaddr_t a;
    e0 = errors;
    @(negedge clk);
    check_word("read after reset", 16'(read), 16'd0);
    check_word("de after reset", 16'(de), 16'd0);
    check_word("hs after reset", 16'(hs), 16'd1);
    check_word("vs after reset", 16'(vs), 16'd1);
    check_rgb("rgb after reset", rgb, 9'd0);
    check_addr("vaddr port after reset", vaddr, cpu_reg_pkg::BASE_DEFAULT);
    read_vaddr(a);
    check_addr("vaddr readback after reset", a, cpu_reg_pkg::BASE_DEFAULT);
    reg_read(cpu_reg_pkg::ADDR_BASE_HI, w);
    check_word("base high after reset", w, {8'h00, cpu_reg_pkg::BASE_DEFAULT[22:15]});
    reg_read(cpu_reg_pkg::ADDR_BASE_MID, w);
    check_word("base mid after reset", w, {8'h00, cpu_reg_pkg::BASE_DEFAULT[14:7]});
    reg_read(cpu_reg_pkg::ADDR_SHMODE, w);
    check_word("shift mode after reset", w, {6'd0, shifter_pkg::SH_MONO, 8'd0});
    end_test("reset", e0);
  endtask

  task automatic test_registers();
    int e0;
    shifter_pkg::word_t w;
    shifter_pkg::rgb_t c;
    e0 = errors;
    write_base(16'h1234);
    reg_read(cpu_reg_pkg::ADDR_BASE_HI, w);
    check_word("base high", w, 16'h0012);
    reg_read(cpu_reg_pkg::ADDR_BASE_MID, w);
    check_word("base mid", w, 16'h0034);
    // byte holds while its low lane strobe is inactive
    reg_write(cpu_reg_pkg::ADDR_BASE_HI, 16'h00ff, 1'b0, 1'b1);
    reg_read(cpu_reg_pkg::ADDR_BASE_HI, w);
    check_word("base high with lds high", w, 16'h0012);
    c = shifter_pkg::rgb_t'($random(seed));
    write_palette(5, c);
    reg_read(6'(cpu_reg_pkg::ADDR_PALETTE + 5), w);
    check_word("palette 5", w, {5'd0, c.r, 1'b0, c.g, 1'b0, c.b});
    // red holds with the upper lane off
    reg_write(6'(cpu_reg_pkg::ADDR_PALETTE + 5),
              {5'd0, ~c.r, 1'b0, ~c.g, 1'b0, ~c.b}, 1'b1, 1'b0);
    reg_read(6'(cpu_reg_pkg::ADDR_PALETTE + 5), w);
    check_word("palette 5 with uds high", w, {5'd0, c.r, 1'b0, ~c.g, 1'b0, ~c.b});
    set_mode(shifter_pkg::SH_MED);
    reg_read(cpu_reg_pkg::ADDR_SHMODE, w);
    check_word("shift mode medium", w, {6'd0, shifter_pkg::SH_MED, 8'd0});
    set_mode(shifter_pkg::SH_MONO);
    write_palette(5, 9'd0);
    end_test("registers", e0);
  endtask

  task automatic test_mono();
    int e0;
    e0 = errors;
    // changes land in vertical blank where nothing is fetched
    @(negedge vs);
    key = shifter_pkg::word_t'($random(seed));
    write_base(16'h3a5c);
    @(posedge vs);
    check_frame(shifter_pkg::SH_MONO);
    @(negedge vs);
    write_palette(0, 9'b000_000_001);
    @(posedge vs);
    check_frame(shifter_pkg::SH_MONO);
    end_test("mono", e0);
  endtask

  task automatic test_color(shifter_pkg::shmode_t m, string name);
    int e0;
    e0 = errors;
    @(negedge vs);
    key = shifter_pkg::word_t'($random(seed));
    for (int i = 0; i < 16; i++) begin
      write_palette(i, shifter_pkg::rgb_t'($random(seed)));
    end
    set_mode(m);
    @(posedge vs);
    check_frame(m);
    end_test(name, e0);
  endtask

  task automatic test_fetch();
    int e0;
    int reads;
    int exp_reads;
    int hs_n;
    int vs_n;
    logic hs_prev;
    logic vs_prev;
    logic done;
    shifter_pkg::vaddr_t a;
    shifter_pkg::shmode_t modes [2];
    e0 = errors;
    modes[0] = shifter_pkg::SH_MONO;
    modes[1] = shifter_pkg::SH_MED;
    for (int k = 0; k < 2; k++) begin
      @(negedge vs);
      set_mode(modes[k]);
      @(posedge vs);
      reads = 0;
      hs_n = 0;
      vs_n = 0;
      hs_prev = hs;
      vs_prev = vs;
      done = 1'b0;
      while (!done) begin
        @(negedge clk);
        if (read) reads++;
        if (hs_prev && !hs) hs_n++;
        if (vs_prev && !vs) vs_n++;
        done = !vs_prev && vs;
        hs_prev = hs;
        vs_prev = vs;
      end
      if (modes[k] == shifter_pkg::SH_MONO) begin
        exp_reads = shifter_pkg::WORDS_MONO * v_act;
        check_word("mono reads per frame", 16'(reads), 16'(exp_reads));
      end else begin
        exp_reads = shifter_pkg::WORDS_COLOR * (v_act / 2);
        check_word("color reads per frame", 16'(reads), 16'(exp_reads));
      end
      check_word("hsync pulses per frame", 16'(hs_n), 16'(v_tot));
      check_word("vsync pulses per frame", 16'(vs_n), 16'd1);
      // one frame of words past the reloaded base
      @(negedge vs);
      read_vaddr(a);
      check_addr("vaddr at frame end", a, base_m + shifter_pkg::vaddr_t'(exp_reads));
    end
    end_test("fetch", e0);
  endtask

  initial begin
    ss = 1'b1;
    data = '0;
    key = '0;
    base_m = cpu_reg_pkg::BASE_DEFAULT;
    for (int i = 0; i < 16; i++) begin
      pal_m[i] = '0;
    end
    reg_idle();
    repeat (16) @(posedge clk);
    #2;
    ss = 1'b0;
    test_reset();
    test_registers();
    test_mono();
    test_color(shifter_pkg::SH_MED, "medium");
    test_color(shifter_pkg::SH_LOW, "low");
    test_fetch();
    $display("tests run %0d, tests failed %0d, errors %0d", tests_run, tests_failed, errors);
    if (errors == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

endmodule

// File: verilog/cpu_reg_pkg.sv
////////////////////////////////////////////////////////////////////////////
// register map, register request struct and reset defaults
////////////////////////////////////////////////////////////////////////////

package cpu_reg_pkg;

  // lane strobes active low, rw high reads
  typedef struct packed {
    logic sel;
    logic rw;
    logic uds;
    logic lds;
    logic [5:0] addr;
    shifter_pkg::word_t din;
  } reg_req_t;

  // base address bits 22:15 and 14:7, low lane
  localparam logic [5:0] ADDR_BASE_HI = 6'h00;
  localparam logic [5:0] ADDR_BASE_MID = 6'h01;

  // current fetch address, read only
  localparam logic [5:0] ADDR_VADDR_HI = 6'h02;
  localparam logic [5:0] ADDR_VADDR_MID = 6'h03;
  localparam logic [5:0] ADDR_VADDR_LO = 6'h04;

  // first of 16 palette entries, 0x20 to 0x2f
  localparam logic [5:0] ADDR_PALETTE = 6'h20;

  // shift mode in bits 9:8, upper lane
  localparam logic [5:0] ADDR_SHMODE = 6'h30;

  localparam shifter_pkg::vaddr_t BASE_DEFAULT = 23'h008000;

endpackage

// File: verilog/line_buffer.sv
////////////////////////////////////////////////////////////////////////////
// two-line ping-pong word store, one write port, one registered read
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module line_buffer (
  input  logic                  clk,
  input  shifter_pkg::buf_wr_t  buf_wr,
  input  shifter_pkg::baddr_t   rd_addr,
  output shifter_pkg::word_t    rd_data
);

  // half 0 at 0..79, half 1 at 80..159
  shifter_pkg::word_t mem [2 * shifter_pkg::BUF_HALF];

  logic wr_upper;
  logic rd_upper;

  assign wr_upper = buf_wr.addr >= 8'(shifter_pkg::BUF_HALF);
  assign rd_upper = rd_addr >= 8'(shifter_pkg::BUF_HALF);

  always_ff @(posedge clk) begin
    if (buf_wr.we) begin
      mem[buf_wr.addr] <= buf_wr.data;
    end
    rd_data <= mem[rd_addr];
  end

  // fetch and shifter must stay on opposite halves
  assert property (@(posedge clk) buf_wr.we |-> (wr_upper != rd_upper));

endmodule

// File: verilog/pixel_shifter.sv
////////////////////////////////////////////////////////////////////////////
// word prefetch, plane shift registers, palette lookup, output registers
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module pixel_shifter #(
  parameter int h_total = 800
) (
  input  logic                    clk,
  input  logic                    ss,
  input  shifter_pkg::beam_t      beam,
  input  shifter_pkg::shmode_t    shmode,
  input  shifter_pkg::palette_t   palette,
  output shifter_pkg::baddr_t     rd_addr,
  input  shifter_pkg::word_t      rd_data,
  output shifter_pkg::rgb_t       rgb,
  output logic                    de,
  output logic                    hs,
  output logic                    vs
);

  // first word group of a line is read just before the line wraps
  localparam logic [9:0] pre_hcnt = 10'(h_total - 8);

  logic is_low;
  logic is_mono;
  logic load_ev;
  logic shift_ev;
  logic pre_ev;
  logic ahead;
  logic rd_half;
  logic rv_q;
  logic mono_bit;
  logic [9:0] p;
  logic [9:0] src;
  logic [2:0] nwords;
  logic [2:0] rcnt;
  logic [1:0] rslot;
  logic [1:0] rslot_q;
  logic [6:0] ridx;
  logic [3:0] cidx;
  logic [1:0] de_d;
  logic [1:0] hs_d;
  logic [1:0] vs_d;
  shifter_pkg::word_t hold [4];
  shifter_pkg::word_t sh [4];
  shifter_pkg::rgb_t pix;

  assign is_low = shmode == shifter_pkg::SH_LOW;
  assign is_mono = shmode == shifter_pkg::SH_MONO;
  assign nwords = is_low ? 3'd4 : (is_mono ? 3'd1 : 3'd2);

  // pixel at the shift register top, two clocks behind the beam
  assign p = beam.hcnt - 10'd2;
  // low loads every 32 clocks, the others every 16
  assign load_ev = (beam.hcnt < 10'(shifter_pkg::H_ACT)) &&
                   (is_low ? (p[4:0] == 5'h1f) : (p[3:0] == 4'hf));
  assign shift_ev = is_low ? p[0] : 1'b1;
  assign pre_ev = beam.hcnt == pre_hcnt;

  // source line, the next one once the prefetch point is passed
  assign ahead = beam.hcnt >= pre_hcnt;
  assign src = beam.vcnt - 10'd1 + {9'd0, ahead};
  assign rd_half = is_mono ? src[0] : src[1];
  assign rd_addr = rd_half ? 8'(shifter_pkg::BUF_HALF) + {1'b0, ridx} : {1'b0, ridx};

  // read sequencer, a burst of nwords after every load
  always_ff @(posedge clk or posedge ss) begin
    if (ss) begin
      rcnt <= '0;
      ridx <= '0;
      rslot <= '0;
      rslot_q <= '0;
      rv_q <= 1'b0;
    end else begin
      rv_q <= rcnt != 3'd0;
      rslot_q <= rslot;
      if (pre_ev) begin
        rcnt <= nwords;
        ridx <= '0;
        rslot <= '0;
      end else if (load_ev) begin
        rcnt <= nwords;
        rslot <= '0;
      end else if (rcnt != 3'd0) begin
        rcnt <= rcnt - 3'd1;
        rslot <= rslot + 2'd1;
        // stays inside one half past the line end
        if (ridx < 7'(shifter_pkg::BUF_HALF - 1)) begin
          ridx <= ridx + 7'd1;
        end
      end
    end
  end

  // holding words, then planes; unused planes load zero
  always_ff @(posedge clk) begin
    if (rv_q) begin
      hold[rslot_q] <= rd_data;
    end
    for (int i = 0; i < 4; i++) begin
      if (load_ev) begin
        sh[i] <= (i < nwords) ? hold[i] : '0;
      end else if (shift_ev) begin
        sh[i] <= {sh[i][14:0], 1'b0};
      end
    end
  end

  // plane 0 is the lsb of the color index
  assign cidx = {sh[3][15], sh[2][15], sh[1][15], sh[0][15]};
  assign mono_bit = sh[0][15] ^ palette[0].b[0];

  always_comb begin
    if (is_mono) begin
      pix = de_d[1] ? shifter_pkg::rgb_t'({9{mono_bit}}) : '0;
    end else begin
      pix = de_d[1] ? palette[cidx] : palette[0];
    end
  end

  // syncs follow the pixel, three clocks after the beam
  always_ff @(posedge clk or posedge ss) begin
    if (ss) begin
      de_d <= '0;
      hs_d <= '0;
      vs_d <= '0;
      rgb <= '0;
      de <= 1'b0;
      hs <= 1'b1;
      vs <= 1'b1;
    end else begin
      de_d <= {de_d[0], beam.de};
      hs_d <= {hs_d[0], beam.hs};
      vs_d <= {vs_d[0], beam.vs};
      rgb <= pix;
      de <= de_d[1];
      hs <= ~hs_d[1];
      vs <= ~vs_d[1];
    end
  end

endmodule

// File: verilog/shifter_pkg.sv
////////////////////////////////////////////////////////////////////////////
// video data types, shift modes, beam and buffer structs, fetch constants
////////////////////////////////////////////////////////////////////////////

package shifter_pkg;

  // active clocks per line
  localparam int H_ACT = 640;
  // clocks between two memory read strobes
  localparam int FETCH_SPACING = 8;
  // words per fetched line
  localparam int WORDS_COLOR = 80;
  localparam int WORDS_MONO = 40;
  // one half of the ping-pong line buffer
  localparam int BUF_HALF = 80;

  typedef logic [15:0] word_t;
  typedef logic [22:0] vaddr_t;
  // line buffer word address, both halves
  typedef logic [7:0] baddr_t;

  typedef enum logic [1:0] {
    SH_LOW = 2'd0,
    SH_MED = 2'd1,
    SH_MONO = 2'd2
  } shmode_t;

  typedef struct packed {
    logic [2:0] r;
    logic [2:0] g;
    logic [2:0] b;
  } rgb_t;

  // 16 entries, entry 0 is also the border
  typedef rgb_t [15:0] palette_t;

  typedef struct packed {
    logic [9:0] rsvd;
    logic [9:0] hcnt;
    logic [9:0] vcnt;
    logic de;
    logic hs;
    logic vs;
    // last cycle of the line
    logic line_start;
    // last cycle of the frame
    logic frame_end;
    logic fetch_line;
  } beam_t;

  typedef struct packed {
    logic we;
    baddr_t addr;
    word_t data;
  } buf_wr_t;

endpackage

// File: verilog/video_fetch.sv
////////////////////////////////////////////////////////////////////////////
// memory read strobes, fetch address counter, line buffer writes
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module video_fetch #(
  parameter int v_active = 400
) (
  input  logic                   clk,
  input  logic                   ss,
  input  shifter_pkg::beam_t     beam,
  input  shifter_pkg::shmode_t   shmode,
  input  shifter_pkg::vaddr_t    base,
  input  shifter_pkg::word_t     data,
  output shifter_pkg::vaddr_t    vaddr,
  output logic                   read,
  output shifter_pkg::buf_wr_t   buf_wr
);

  // fetching starts with the first full frame
  logic run;
  logic read_q;
  logic mono;
  logic wr_half;
  logic [6:0] wcnt;
  logic [6:0] words;
  logic [6:0] widx;

  assign mono = shmode == shifter_pkg::SH_MONO;
  assign words = mono ? 7'(shifter_pkg::WORDS_MONO) : 7'(shifter_pkg::WORDS_COLOR);

  // one strobe per spacing slot until the line is complete
  assign read = run && beam.fetch_line &&
                ((beam.hcnt % shifter_pkg::FETCH_SPACING) == 0) && (wcnt < words);

  // mono half from line bit 0, color half from source row bit 0
  assign wr_half = mono ? beam.vcnt[0] : beam.vcnt[1];
  // counter already advanced when the data arrives
  assign widx = wcnt - 7'd1;

  // memory data comes back one cycle after the strobe
  assign buf_wr = '{
    we: read_q && beam.fetch_line,
    addr: wr_half ? 8'(shifter_pkg::BUF_HALF) + {1'b0, widx} : {1'b0, widx},
    data: data
  };

  always_ff @(posedge clk or posedge ss) begin
    if (ss) begin
      run <= 1'b0;
      read_q <= 1'b0;
      wcnt <= '0;
      vaddr <= cpu_reg_pkg::BASE_DEFAULT;
    end else begin
      read_q <= read;
      // word count per line
      if (beam.line_start) begin
        wcnt <= '0;
      end else if (read) begin
        wcnt <= wcnt + 7'd1;
      end
      // new base picked up once per frame
      if (beam.frame_end) begin
        vaddr <= base;
        run <= 1'b1;
      end else if (read) begin
        vaddr <= vaddr + 23'd1;
      end
    end
  end

  // strobes only on fetch lines and never back to back
  assert property (@(posedge clk) disable iff (ss)
    read |-> (beam.fetch_line && (beam.vcnt < 10'(v_active))) ##1 !read);

endmodule

// File: verilog/video_regs.sv
////////////////////////////////////////////////////////////////////////////
// cpu register file with byte lanes, readback mux
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module video_regs #(
  parameter shifter_pkg::shmode_t default_mode = shifter_pkg::SH_MONO
) (
  input  logic                   clk,
  input  logic                   ss,
  input  cpu_reg_pkg::reg_req_t  reg_req,
  input  shifter_pkg::vaddr_t    vaddr,
  output shifter_pkg::word_t     reg_dout,
  output shifter_pkg::vaddr_t    base,
  output shifter_pkg::shmode_t   shmode,
  output shifter_pkg::palette_t  palette
);

  // base bits 22:7, lower bits always zero
  logic [15:0] base_r;
  logic wr;
  logic rd;
  logic pal_sel;
  logic [3:0] pal_idx;

  assign wr = reg_req.sel && !reg_req.rw;
  assign rd = reg_req.sel && reg_req.rw;
  assign pal_sel = reg_req.addr[5:4] == cpu_reg_pkg::ADDR_PALETTE[5:4];
  assign pal_idx = reg_req.addr[3:0];
  assign base = {base_r, 7'd0};

  always_ff @(posedge clk or posedge ss) begin
    if (ss) begin
      base_r <= cpu_reg_pkg::BASE_DEFAULT[22:7];
      shmode <= default_mode;
      palette <= '0;
    end else if (wr) begin
      // base bytes on the low lane
      if ((reg_req.addr == cpu_reg_pkg::ADDR_BASE_HI) && !reg_req.lds) begin
        base_r[15:8] <= reg_req.din[7:0];
      end
      if ((reg_req.addr == cpu_reg_pkg::ADDR_BASE_MID) && !reg_req.lds) begin
        base_r[7:0] <= reg_req.din[7:0];
      end
      // red upper lane, green and blue lower lane
      if (pal_sel) begin
        if (!reg_req.uds) begin
          palette[pal_idx].r <= reg_req.din[10:8];
        end
        if (!reg_req.lds) begin
          palette[pal_idx].g <= reg_req.din[6:4];
          palette[pal_idx].b <= reg_req.din[2:0];
        end
      end
      if ((reg_req.addr == cpu_reg_pkg::ADDR_SHMODE) && !reg_req.uds) begin
        shmode <= shifter_pkg::shmode_t'(reg_req.din[9:8]);
      end
    end
  end

  // readback, zero when idle
  always_comb begin
    reg_dout = '0;
    if (rd && pal_sel) begin
      reg_dout[10:8] = palette[pal_idx].r;
      reg_dout[6:4] = palette[pal_idx].g;
      reg_dout[2:0] = palette[pal_idx].b;
    end else if (rd) begin
      case (reg_req.addr)
        cpu_reg_pkg::ADDR_BASE_HI:
          if (!reg_req.lds) reg_dout = {8'h00, base_r[15:8]};
        cpu_reg_pkg::ADDR_BASE_MID:
          if (!reg_req.lds) reg_dout = {8'h00, base_r[7:0]};
        cpu_reg_pkg::ADDR_VADDR_HI:
          if (!reg_req.lds) reg_dout = {8'h00, vaddr[22:15]};
        cpu_reg_pkg::ADDR_VADDR_MID:
          if (!reg_req.lds) reg_dout = {8'h00, vaddr[14:7]};
        // word address, so byte bit 0 reads zero
        cpu_reg_pkg::ADDR_VADDR_LO:
          if (!reg_req.lds) reg_dout = {8'h00, vaddr[6:0], 1'b0};
        cpu_reg_pkg::ADDR_SHMODE:
          if (!reg_req.uds) reg_dout = {6'h00, shmode, 8'h00};
        default:
          reg_dout = '0;
      endcase
    end
  end

endmodule

// File: verilog/video_timing.sv
////////////////////////////////////////////////////////////////////////////
// beam counters, sync and display enable decode, line and frame strobes
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module video_timing #(
  parameter int v_active = 400,
  parameter int h_total = 800,
  parameter int v_total = 450,
  parameter int hs_start = 656,
  parameter int hs_width = 96,
  parameter int vs_start = 420,
  parameter int vs_width = 3
) (
  input  logic                 clk,
  input  logic                 ss,
  input  shifter_pkg::shmode_t shmode,
  output shifter_pkg::beam_t   beam
);

  // vsync pulled back into a shortened frame
  localparam int vs_pos = (vs_start + vs_width <= v_total) ? vs_start : v_total - vs_width;

  logic [9:0] hcnt;
  logic [9:0] vcnt;
  logic h_last;
  logic v_last;
  logic disp_line;
  logic fetch_line;

  assign h_last = hcnt == 10'(h_total - 1);
  assign v_last = vcnt == 10'(v_total - 1);

  // free running beam position
  always_ff @(posedge clk or posedge ss) begin
    if (ss) begin
      hcnt <= '0;
      vcnt <= '0;
    end else if (h_last) begin
      hcnt <= '0;
      vcnt <= v_last ? '0 : vcnt + 10'd1;
    end else begin
      hcnt <= hcnt + 10'd1;
    end
  end

  // lines shown one after their fetch
  assign disp_line = (vcnt >= 10'd1) && (vcnt <= 10'(v_active));

  // color modes fetch every other line, scan doubled on display
  assign fetch_line = (vcnt < 10'(v_active)) &&
                      ((shmode == shifter_pkg::SH_MONO) || !vcnt[0]);

  assign beam = '{
    rsvd: '0,
    hcnt: hcnt,
    vcnt: vcnt,
    de: disp_line && (hcnt < 10'(shifter_pkg::H_ACT)),
    hs: (hcnt >= 10'(hs_start)) && (hcnt < 10'(hs_start + hs_width)),
    vs: (vcnt >= 10'(vs_pos)) && (vcnt < 10'(vs_pos + vs_width)),
    line_start: h_last,
    frame_end: h_last && v_last,
    fetch_line: fetch_line
  };

  // counters stay in range
  assert property (@(posedge clk) disable iff (ss)
    (hcnt < 10'(h_total)) && (vcnt < 10'(v_total)));

endmodule

// File: verilog/video_top.sv
////////////////////////////////////////////////////////////////////////////
// video shifter top level, timing, registers, fetch, buffer and shifter
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module video_top #(
  parameter int v_active = 400,
  parameter int h_total = 800,
  parameter int v_total = 450,
  parameter int hs_start = 656,
  parameter int hs_width = 96,
  parameter int vs_start = 420,
  parameter int vs_width = 3,
  parameter shifter_pkg::shmode_t default_mode = shifter_pkg::SH_MONO
) (
  input  logic                   clk,
  input  logic                   ss,
  input  cpu_reg_pkg::reg_req_t  reg_req,
  output shifter_pkg::word_t     reg_dout,
  output shifter_pkg::vaddr_t    vaddr,
  output logic                   read,
  input  shifter_pkg::word_t     data,
  output shifter_pkg::rgb_t      rgb,
  output logic                   hs,
  output logic                   vs,
  output logic                   de
);

  shifter_pkg::beam_t beam;
  shifter_pkg::vaddr_t base;
  shifter_pkg::shmode_t shmode;
  shifter_pkg::palette_t palette;
  shifter_pkg::buf_wr_t buf_wr;
  shifter_pkg::baddr_t rd_addr;
  shifter_pkg::word_t rd_data;

  video_timing #(
    .v_active (v_active),
    .h_total  (h_total),
    .v_total  (v_total),
    .hs_start (hs_start),
    .hs_width (hs_width),
    .vs_start (vs_start),
    .vs_width (vs_width)
  ) u_timing (
    .clk    (clk),
    .ss     (ss),
    .shmode (shmode),
    .beam   (beam)
  );

  video_regs #(
    .default_mode (default_mode)
  ) u_regs (
    .clk      (clk),
    .ss       (ss),
    .reg_req  (reg_req),
    .vaddr    (vaddr),
    .reg_dout (reg_dout),
    .base     (base),
    .shmode   (shmode),
    .palette  (palette)
  );

  // producer side
  video_fetch #(
    .v_active (v_active)
  ) u_fetch (
    .clk    (clk),
    .ss     (ss),
    .beam   (beam),
    .shmode (shmode),
    .base   (base),
    .data   (data),
    .vaddr  (vaddr),
    .read   (read),
    .buf_wr (buf_wr)
  );

  line_buffer u_buffer (
    .clk     (clk),
    .buf_wr  (buf_wr),
    .rd_addr (rd_addr),
    .rd_data (rd_data)
  );

  // consumer side
  pixel_shifter #(
    .h_total (h_total)
  ) u_shifter (
    .clk     (clk),
    .ss      (ss),
    .beam    (beam),
    .shmode  (shmode),
    .palette (palette),
    .rd_addr (rd_addr),
    .rd_data (rd_data),
    .rgb     (rgb),
    .de      (de),
    .hs      (hs),
    .vs      (vs)
  );

endmodule
